// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exponentiation
FILELIST  ?= exponentiation.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/modexp_pkg.sv
package modexp_pkg;

    // what a start pulse asks for
    typedef enum logic {
        op_exp      = 1'b0,  // x^e mod m
        op_mont_mul = 1'b1   // x*y*R^-1 mod m, y on r2_mod_m
    } op_t;

    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_skip_zeros = 3'd1,
        st_to_mont    = 3'd2,
        st_square     = 3'd3,
        st_multiply   = 3'd4,
        st_from_mont  = 3'd5,
        st_mul_only   = 3'd6,
        st_done       = 3'd7
    } exp_state_t;

    // second multiplier operand
    typedef enum logic [1:0] {
        sel_b_pre = 2'd0,  // x image, or captured r2 before the image exists
        sel_b_acc = 2'd1,
        sel_b_one = 2'd2
    } sel_b_t;

    // controller to datapath strobes
    typedef struct packed {
        logic   capture;         // latch operands on start
        logic   a_load_r;        // acc <= R mod m
        logic   a_load_result;   // acc <= product, on mult_done
        logic   xm_load_result;  // x image <= product, on mult_done
        logic   sel_a_x;         // operand a is x, else acc
        sel_b_t sel_b;
        logic   exp_shift;       // next exponent bit
    } dp_ctrl_t;

endpackage

// File: exponentiation.f
+incdir+tb
common/modexp_pkg.sv
montgomery/montgomery_mult.sv
exponentiation/exp_controller.sv
exponentiation/exp_datapath.sv
exponentiation/exponentiation.sv
tb/tb_exponentiation.sv

// File: exponentiation/exp_controller.sv
module exp_controller
    import modexp_pkg::*;
#(
    parameter int WIDTH = 64
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  op_t      op,
    input  logic     lead_bit,
    input  logic     last_bit,
    input  logic     mult_done,
    output dp_ctrl_t ctrl,
    output logic     mult_start,
    output logic     done
);

    exp_state_t state;
    exp_state_t state_nxt;
    logic       issued;      // product in flight for this state
    logic       mult_state;

    assign mult_state = state inside {st_to_mont, st_square, st_multiply,
                                      st_from_mont, st_mul_only};
    assign mult_start = mult_state && !issued;
    assign done       = (state == st_done);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state  <= st_idle;
            issued <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (mult_done)
                issued <= 1'b0;
            else if (mult_start)
                issued <= 1'b1;
        end
    end

    always_comb
    begin
        state_nxt = state;
        ctrl      = '0;
        unique case (state)
            st_idle:
            begin
                if (start)
                begin
                    ctrl.capture = 1'b1;
                    state_nxt    = (op == op_exp) ? st_skip_zeros : st_mul_only;
                end
            end
            st_skip_zeros:
            begin
                if (lead_bit)
                    state_nxt = st_to_mont;
                else if (last_bit)
                begin
                    ctrl.a_load_r = 1'b1;  // zero exponent yields R*R^-1
                    state_nxt     = st_from_mont;
                end
                else
                    ctrl.exp_shift = 1'b1;
            end
            st_to_mont:
            begin
                ctrl.sel_a_x        = 1'b1;  // x * R^2 * R^-1
                ctrl.sel_b          = sel_b_pre;
                ctrl.a_load_r       = 1'b1;
                ctrl.xm_load_result = 1'b1;
                if (mult_done)
                    state_nxt = st_square;
            end
            st_square:
            begin
                ctrl.sel_b         = sel_b_acc;
                ctrl.a_load_result = 1'b1;
                if (mult_done)
                begin
                    if (lead_bit)
                        state_nxt = st_multiply;
                    else if (last_bit)
                        state_nxt = st_from_mont;
                    else
                        ctrl.exp_shift = 1'b1;
                end
            end
            st_multiply:
            begin
                ctrl.sel_b         = sel_b_pre;
                ctrl.a_load_result = 1'b1;
                if (mult_done)
                begin
                    if (last_bit)
                        state_nxt = st_from_mont;
                    else
                    begin
                        ctrl.exp_shift = 1'b1;
                        state_nxt      = st_square;
                    end
                end
            end
            st_from_mont:
            begin
                ctrl.sel_b         = sel_b_one;
                ctrl.a_load_result = 1'b1;
                if (mult_done)
                    state_nxt = st_done;
            end
            st_mul_only:
            begin
                ctrl.sel_a_x       = 1'b1;
                ctrl.sel_b         = sel_b_pre;
                ctrl.a_load_result = 1'b1;
                if (mult_done)
                    state_nxt = st_done;
            end
            st_done:   state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
    end

    // a multiplier completion always answers a product issued here
    a_done_issued: assert property (@(posedge clk) disable iff (!resetn)
        mult_done |-> issued);

    a_start_pulse: assert property (@(posedge clk) disable iff (!resetn)
        mult_start |=> !mult_start);

    // multiplier latency the state timing relies on
    a_mult_latency: assert property (@(posedge clk) disable iff (!resetn)
        mult_start |=> !mult_done [*(WIDTH+1)] ##1 mult_done);

endmodule

// File: exponentiation/exp_datapath.sv
module exp_datapath
    import modexp_pkg::*;
#(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             resetn,
    input  dp_ctrl_t         ctrl,
    input  logic [WIDTH-1:0] modulus,
    input  logic [WIDTH-1:0] r_mod_m,
    input  logic [WIDTH-1:0] r2_mod_m,
    input  logic [WIDTH-1:0] exponent,
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] mult_result,
    input  logic             mult_done,
    output logic [WIDTH-1:0] mult_a,
    output logic [WIDTH-1:0] mult_b,
    output logic [WIDTH-1:0] mult_m,
    output logic             lead_bit,
    output logic             last_bit,
    output logic [WIDTH-1:0] result
);

    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [WIDTH-1:0] mod_q;
    logic [WIDTH-1:0] r_q;
    logic [WIDTH-1:0] r2_q;     // R^2 mod m, or y in product mode
    logic [WIDTH-1:0] x_q;
    logic [WIDTH-1:0] exp_q;
    logic [CNT_W-1:0] bit_cnt;
    logic [WIDTH-1:0] acc;
    logic [WIDTH-1:0] xm;       // x in the Montgomery domain
    logic             xm_ready;

    always_ff @(posedge clk)
    begin
        if (ctrl.capture)
        begin
            mod_q <= modulus;
            r_q   <= r_mod_m;
            r2_q  <= r2_mod_m;
            x_q   <= x;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.capture)
            exp_q <= exponent;
        else if (ctrl.exp_shift)
            exp_q <= {exp_q[WIDTH-2:0], 1'b0};
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            bit_cnt  <= '0;
            acc      <= '0;
            xm_ready <= 1'b0;
        end
        else
        begin
            if (ctrl.capture)
                bit_cnt <= '0;
            else if (ctrl.exp_shift)
                bit_cnt <= bit_cnt + 1'b1;

            if (ctrl.a_load_r)
                acc <= r_q;
            else if (ctrl.a_load_result && mult_done)
                acc <= mult_result;

            if (ctrl.capture)
                xm_ready <= 1'b0;
            else if (ctrl.xm_load_result && mult_done)
                xm_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.xm_load_result && mult_done)
            xm <= mult_result;
    end

    assign mult_a = ctrl.sel_a_x ? x_q : acc;

    always_comb
    begin
        unique case (ctrl.sel_b)
            sel_b_pre: mult_b = xm_ready ? xm : r2_q;
            sel_b_acc: mult_b = acc;
            default:   mult_b = WIDTH'(1);  // leave the Montgomery domain
        endcase
    end

    assign mult_m   = mod_q;
    assign lead_bit = exp_q[WIDTH-1];
    assign last_bit = (bit_cnt == CNT_W'(WIDTH - 1));
    assign result   = acc;

    a_no_shift_on_capture: assert property (@(posedge clk) disable iff (!resetn)
        !(ctrl.exp_shift && ctrl.capture));

endmodule

// File: exponentiation/exponentiation.sv
module exponentiation
    import modexp_pkg::*;
#(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  op_t              op,
    input  logic [WIDTH-1:0] modulus,
    input  logic [WIDTH-1:0] r_mod_m,
    input  logic [WIDTH-1:0] r2_mod_m,   // y in product mode
    input  logic [WIDTH-1:0] exponent,
    input  logic [WIDTH-1:0] x,
    output logic             done,
    output logic [WIDTH-1:0] result
);

    dp_ctrl_t         ctrl;
    logic             lead_bit;
    logic             last_bit;
    logic             mult_start;
    logic             mult_done;
    logic [WIDTH-1:0] mult_a;
    logic [WIDTH-1:0] mult_b;
    logic [WIDTH-1:0] mult_m;
    logic [WIDTH-1:0] mult_result;

    exp_controller #(
        .WIDTH (WIDTH)
    ) i_exp_controller (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .op         (op),
        .lead_bit   (lead_bit),
        .last_bit   (last_bit),
        .mult_done  (mult_done),
        .ctrl       (ctrl),
        .mult_start (mult_start),
        .done       (done)
    );

    exp_datapath #(
        .WIDTH (WIDTH)
    ) i_exp_datapath (
        .clk         (clk),
        .resetn      (resetn),
        .ctrl        (ctrl),
        .modulus     (modulus),
        .r_mod_m     (r_mod_m),
        .r2_mod_m    (r2_mod_m),
        .exponent    (exponent),
        .x           (x),
        .mult_result (mult_result),
        .mult_done   (mult_done),
        .mult_a      (mult_a),
        .mult_b      (mult_b),
        .mult_m      (mult_m),
        .lead_bit    (lead_bit),
        .last_bit    (last_bit),
        .result      (result)
    );

    montgomery_mult #(
        .WIDTH (WIDTH)
    ) i_montgomery_mult (
        .clk    (clk),
        .resetn (resetn),
        .start  (mult_start),
        .a      (mult_a),
        .b      (mult_b),
        .m      (mult_m),
        .result (mult_result),
        .done   (mult_done)
    );

endmodule

// File: montgomery/montgomery_mult.sv
module montgomery_mult #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] m,
    output logic [WIDTH-1:0] result,
    output logic             done
);

    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic             busy;       // iterating
    logic             sub_phase;  // final subtract cycle
    logic [CNT_W-1:0] iter;
    logic             accept;

    logic [WIDTH-1:0] a_shift;
    logic [WIDTH-1:0] b_q;
    logic [WIDTH-1:0] m_q;
    logic [WIDTH+1:0] sum;        // partial sum, stays below 2m
    logic [WIDTH+1:0] sum_b;
    logic [WIDTH+1:0] sum_bm;
    logic [WIDTH+1:0] sum_sub;
    logic             sum_ge_m;

    assign accept = start && !busy && !sub_phase;

    // one radix-2 step: add b on the current a bit, make even with m
    always_comb
    begin
        sum_b    = sum + (a_shift[0] ? {2'b00, b_q} : '0);
        sum_bm   = sum_b + (sum_b[0] ? {2'b00, m_q} : '0);
        sum_sub  = sum - {2'b00, m_q};
        sum_ge_m = (sum >= {2'b00, m_q});
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            busy      <= 1'b0;
            sub_phase <= 1'b0;
            iter      <= '0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (accept)
            begin
                busy <= 1'b1;
                iter <= '0;
            end
            else if (busy)
            begin
                iter <= iter + 1'b1;
                if (iter == CNT_W'(WIDTH - 1))
                begin
                    busy      <= 1'b0;
                    sub_phase <= 1'b1;
                end
            end
            else if (sub_phase)
            begin
                sub_phase <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    // operand and sum registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            a_shift <= a;
            b_q     <= b;
            m_q     <= m;
            sum     <= '0;
        end
        else if (busy)
        begin
            a_shift <= a_shift >> 1;
            sum     <= sum_bm >> 1;
        end
    end

    // held until the next product completes
    always_ff @(posedge clk)
    begin
        if (sub_phase)
            result <= sum_ge_m ? sum_sub[WIDTH-1:0] : sum[WIDTH-1:0];
    end

    // the controller waits for done before issuing the next product
    a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
        start |-> !busy && !sub_phase);

endmodule

// File: tb/modexp_ref.svh
`ifndef MODEXP_REF_SVH
`define MODEXP_REF_SVH

logic [31:0] lfsr_state = 32'h4f98;

// (a * b) mod m over a full 64-bit product
function automatic logic [31:0] mulmod(input logic [31:0] a, input logic [31:0] b,
                                       input logic [31:0] m);
    logic [63:0] prod;
    logic [63:0] rem;
    prod = {32'd0, a} * {32'd0, b};
    rem  = prod % {32'd0, m};
    return rem[31:0];
endfunction

function automatic logic [31:0] modexp_ref(input logic [31:0] base, input logic [31:0] e,
                                           input logic [31:0] m);
    logic [31:0] acc;
    acc = 32'd1 % m;
    for (int i = 31; i >= 0; i--)
    begin
        acc = mulmod(acc, acc, m);
        if (e[i])
            acc = mulmod(acc, base, m);
    end
    return acc;
endfunction

function automatic logic [31:0] r_mod(input logic [31:0] m);
    logic [63:0] rem;
    rem = 64'h1_0000_0000 % {32'd0, m};  // R = 2^32
    return rem[31:0];
endfunction

function automatic logic [31:0] r2_mod(input logic [31:0] m);
    return mulmod(r_mod(m), r_mod(m), m);
endfunction

// x*y mod m, then 32 halvings mod m give the R^-1 factor
function automatic logic [31:0] mont_ref(input logic [31:0] a, input logic [31:0] b,
                                         input logic [31:0] m);
    logic [31:0] p;
    logic [32:0] t;
    p = mulmod(a, b, m);
    for (int i = 0; i < 32; i++)
    begin
        t = p[0] ? ({1'b0, p} + {1'b0, m}) : {1'b0, p};
        p = t[32:1];
    end
    return p;
endfunction

// taps 32, 22, 2, 1
function automatic logic lfsr_next_bit();
    logic out;
    logic fb;
    out        = lfsr_state[31];
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return out;
endfunction

function automatic logic [31:0] random_word(input int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++)
        w = {w[30:0], lfsr_next_bit()};
    return w;
endfunction

`endif

// File: tb/tb_exponentiation.sv
module tb_exponentiation
    import modexp_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WIDTH        = 32;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_OPS      = 35;
    localparam int OP_CYCLES    = 2 * WIDTH * (WIDTH + 4) + 100;  // worst case per operation

    logic             clk;
    logic             resetn;
    logic             start;
    op_t              op;
    logic [WIDTH-1:0] modulus;
    logic [WIDTH-1:0] r_mod_m;
    logic [WIDTH-1:0] r2_mod_m;
    logic [WIDTH-1:0] exponent;
    logic [WIDTH-1:0] x;
    logic             done;
    logic [WIDTH-1:0] result;
    int               errors = 0;
    int               checks = 0;

    `include "modexp_ref.svh"

    exponentiation #(
        .WIDTH (WIDTH)
    ) i_exponentiation (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .op       (op),
        .modulus  (modulus),
        .r_mod_m  (r_mod_m),
        .r2_mod_m (r2_mod_m),
        .exponent (exponent),
        .x        (x),
        .done     (done),
        .result   (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(NUM_OPS * OP_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Test failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s finished, %0d errors", name, errors - err_before);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        resetn = 1'b0;
        start  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
    endtask

    task automatic drive_operands(input op_t o, input logic [31:0] m, r, r2, e, xv);
        op       = o;
        modulus  = m;
        r_mod_m  = r;
        r2_mod_m = r2;
        exponent = e;
        x        = xv;
    endtask

    // counts falling edges after the one that drove start
    task automatic wait_done(input string name, output int cycles, output logic seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < OP_CYCLES)
        begin
            @(negedge clk);
            start  = 1'b0;
            cycles = cycles + 1;
            seen   = done;
        end
        if (!seen)
        begin
            errors = errors + 1;
            $display("%s: done did not arrive within %0d cycles", name, OP_CYCLES);
        end
    endtask

    task automatic run_op(input string name, input op_t o, input logic [31:0] m, r, r2, e, xv,
                          output logic [31:0] res, output int cycles);
        logic seen;
        @(negedge clk);
        drive_operands(o, m, r, r2, e, xv);
        start = 1'b1;
        wait_done(name, cycles, seen);
        res = result;
    endtask

    task automatic run_exp_case(input string name, input logic [31:0] m, e, xv,
                                output logic [31:0] res);
        int cycles;
        run_op(name, op_exp, m, r_mod(m), r2_mod(m), e, xv, res, cycles);
        check_value(name, modexp_ref(xv, e, m), res);
    endtask

    task automatic run_mont_case(input string name, input logic [31:0] m, xv, y);
        logic [31:0] res;
        int          cycles;
        run_op(name, op_mont_mul, m, r_mod(m), y, 32'd0, xv, res, cycles);
        check_value(name, mont_ref(xv, y, m), res);
        checks = checks + 1;
        if (cycles != WIDTH + 4)
        begin
            errors = errors + 1;
            $display("** Error %s latency: expected %0d, actual %0d", name, WIDTH + 4, cycles);
        end
    endtask

    task automatic test_after_reset(input string name);
        int err0;
        err0 = errors;
        apply_reset();
        @(negedge clk);
        check_value({name, " done"}, 32'd0, {31'd0, done});
        check_value({name, " result"}, 32'd0, result);
        report_test(name, err0);
    endtask

    task automatic test_known_vectors();
        logic [31:0] res;
        int          err0;
        err0 = errors;
        run_exp_case("known 4^13 mod 497", 32'd497, 32'd13, 32'd4, res);
        check_value("known 4^13 mod 497 literal", 32'd445, res);
        run_exp_case("known 2^10 mod 1001", 32'd1001, 32'd10, 32'd2, res);
        run_exp_case("known 3^200 mod 1000003", 32'd1000003, 32'd200, 32'd3, res);
        run_exp_case("known 12345^65537", 32'd1000003, 32'd65537, 32'd12345, res);
        report_test("known_vectors", err0);
    endtask

    task automatic test_mont_mul();
        int err0;
        err0 = errors;
        run_mont_case("mont_mul small", 32'd497, 32'd5, 32'd7);
        run_mont_case("mont_mul mid", 32'd1000003, 32'd123456, 32'd654321);
        run_mont_case("mont_mul wide", 32'hffff_fffb, 32'h1234_5678, 32'hfedc_ba98);
        report_test("mont_mul", err0);
    endtask

    task automatic test_exp_edges();
        logic [31:0] res;
        int          err0;
        err0 = errors;
        run_exp_case("edge e=0", 32'd1000003, 32'd0, 32'd777, res);
        check_value("edge e=0 literal", 32'd1, res);
        run_exp_case("edge e=0 wide m", 32'hffff_fffb, 32'd0, 32'hdead_beef, res);
        check_value("edge e=0 wide m literal", 32'd1, res);
        run_exp_case("edge e=1", 32'd1000003, 32'd1, 32'd777, res);
        check_value("edge e=1 literal", 32'd777, res);
        run_exp_case("edge top bit", 32'd1000003, 32'h8000_0001, 32'd777, res);
        run_exp_case("edge all ones", 32'hffff_fffb, 32'hffff_ffff, 32'h0bad_cafe, res);
        report_test("exp_edges", err0);
    endtask

    task automatic test_random();
        logic [31:0] m;
        logic [31:0] xv;
        logic [31:0] e;
        logic [31:0] res;
        int          err0;
        err0 = errors;
        for (int i = 0; i < 20; i++)
        begin
            m  = random_word(32) | 32'h8000_0001;  // odd, full width
            xv = random_word(32) % m;
            e  = random_word(32);
            run_exp_case($sformatf("random %0d", i), m, e, xv, res);
        end
        report_test("random", err0);
    endtask

    task automatic test_busy_start();
        logic [31:0] expected;
        logic        seen;
        logic        extra;
        int          cycles;
        int          err0;
        err0     = errors;
        expected = modexp_ref(32'd31337, 32'd65537, 32'd1000003);
        @(negedge clk);
        drive_operands(op_exp, 32'd1000003, r_mod(32'd1000003), r2_mod(32'd1000003),
                       32'd65537, 32'd31337);
        start = 1'b1;
        repeat (5)
        begin
            @(negedge clk);
            start = 1'b0;
        end
        drive_operands(op_mont_mul, 32'hffff_fffb, 32'd5, 32'd9, 32'd3, 32'd7);
        start = 1'b1;  // lands while the core is busy
        wait_done("busy_start", cycles, seen);
        check_value("busy_start", expected, result);
        extra = 1'b0;
        repeat (2 * (WIDTH + 4))
        begin
            @(negedge clk);
            if (done)
                extra = 1'b1;
        end
        checks = checks + 1;
        if (extra)
        begin
            errors = errors + 1;
            $display("busy_start: a second done pulse followed the ignored start");
        end
        report_test("busy_start", err0);
    endtask

    task automatic test_result_hold();
        logic [31:0] held;
        logic [31:0] res;
        logic        bad_value;
        logic        bad_done;
        int          err0;
        err0      = errors;
        bad_value = 1'b0;
        bad_done  = 1'b0;
        run_exp_case("result_hold", 32'd1000003, 32'd65537, 32'd4242, held);
        repeat (3 * WIDTH)
        begin
            @(negedge clk);
            if (!bad_value && result !== held)
            begin
                bad_value = 1'b1;
                errors    = errors + 1;
                $display("** Error result_hold: expected %h, actual %h", held, result);
            end
            if (!bad_done && done)
            begin
                bad_done = 1'b1;
                errors   = errors + 1;
                $display("result_hold: done pulsed without a start");
            end
            drive_operands(op_exp, random_word(32), random_word(32), random_word(32),
                           random_word(32), random_word(32));
        end
        checks = checks + 2;
        run_exp_case("result_hold next", 32'd497, 32'd13, 32'd4, res);
        report_test("result_hold", err0);
    endtask

    initial
    begin
        resetn = 1'b0;
        start  = 1'b0;
        drive_operands(op_exp, '0, '0, '0, '0, '0);
        test_after_reset("reset_state");
        test_known_vectors();
        test_mont_mul();
        test_exp_edges();
        test_random();
        test_busy_start();
        test_result_hold();
        test_after_reset("reset_again");
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
